// ==== flist.f ====
hw/alu_op_pkg.sv
hw/muldiv_pkg.sv
hw/muldiv_if.sv
hw/int_alu.sv
hw/pipe_mul.sv
hw/iter_div.sv
hw/alu_ctrl.sv
hw/alu_top.sv
tests/tb_clock.sv
tests/tb_alu.sv

// ==== hw/alu_ctrl.sv ====
module alu_ctrl #(
   parameter int XLEN = alu_op_pkg::XLEN
) (
   input  logic                clk_i,
   input  logic                rst_i,
   input  logic                valid_i,
   input  alu_op_pkg::alu_op_e op_i,
   input  alu_op_pkg::word_t   rs1_i,
   input  alu_op_pkg::word_t   rs2_i,
   input  alu_op_pkg::word_t   int_res_i,
   muldiv_if.ctrl              mul_o,
   muldiv_if.ctrl              div_o,
   output alu_op_pkg::word_t   result_o,
   output logic                ready_o,
   output logic                stall_o
);
   import alu_op_pkg::*;
   import muldiv_pkg::*;

   logic            is_mul;
   logic            is_div;
   logic            accept;
   logic            busy_q;   // multiply or divide in flight
   logic            ready_q;
   logic [XLEN-1:0] result_q;

   assign is_mul = op_i inside {ALU_MUL, ALU_MULH, ALU_MULHU};
   assign is_div = op_i inside {ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};

   // inputs are still held during the ready cycle, so skip that cycle
   assign accept = valid_i && !busy_q && !ready_q;

   assign mul_o.req = accept && is_mul;
   assign mul_o.a   = rs1_i;
   assign mul_o.b   = rs2_i;
   assign div_o.req = accept && is_div;
   assign div_o.a   = rs1_i;
   assign div_o.b   = rs2_i;

   always_comb begin
      case (op_i)
         ALU_MULH: begin
            mul_o.op  = MD_HI;
            mul_o.sgn = 1'b1;
         end
         ALU_MULHU: begin
            mul_o.op  = MD_HIU;
            mul_o.sgn = 1'b0;
         end
         default: begin
            mul_o.op  = MD_LO;
            mul_o.sgn = 1'b1;
         end
      endcase
      div_o.op  = (op_i inside {ALU_REM, ALU_REMU}) ? MD_HI : MD_LO;
      div_o.sgn = op_i inside {ALU_DIV, ALU_REM};
   end

   assign stall_o = busy_q || (accept && (is_mul || is_div));

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         busy_q   <= 1'b0;
         ready_q  <= 1'b0;
         result_q <= '0;
      end else begin
         ready_q <= 1'b0;
         if (mul_o.done || div_o.done) begin
            busy_q   <= 1'b0;
            ready_q  <= 1'b1;
            result_q <= mul_o.done ? mul_o.res : div_o.res;
         end else if (accept && (is_mul || is_div)) begin
            busy_q <= 1'b1;
         end else if (accept) begin
            ready_q  <= 1'b1;
            result_q <= int_res_i;
         end
      end
   end

   assign result_o = result_q;
   assign ready_o  = ready_q;

   // a unit answers only an operation that was issued to it
   a_done_busy: assert property (@(posedge clk_i) disable iff (!rst_i)
      (mul_o.done || div_o.done) |-> busy_q);

   // a finished op must not be taken a second time from the held inputs
   a_ready_pulse: assert property (@(posedge clk_i) disable iff (!rst_i)
      ready_q |=> !ready_q);

endmodule

// ==== hw/alu_op_pkg.sv ====
package alu_op_pkg;

   parameter int XLEN = 32;

   typedef logic [XLEN-1:0] word_t;

   // encodings follow the decoder's operation list, 6'd4 stays free
   typedef enum logic [5:0] {
      ALU_ADD   = 6'd0,  ALU_ADDI  = 6'd1,  ALU_MUL   = 6'd2,  ALU_MULH  = 6'd3,
      ALU_MULHU = 6'd5,  ALU_DIV   = 6'd6,  ALU_DIVU  = 6'd7,  ALU_REM   = 6'd8,
      ALU_REMU  = 6'd9,  ALU_AUIPC = 6'd10, ALU_LUI   = 6'd11, ALU_JAL   = 6'd12,
      ALU_JALR  = 6'd13, ALU_MEM   = 6'd14, ALU_SUB   = 6'd15, ALU_AND   = 6'd16,
      ALU_ANDI  = 6'd17, ALU_OR    = 6'd18, ALU_XOR   = 6'd19, ALU_ORI   = 6'd20,
      ALU_XORI  = 6'd21, ALU_SLLI  = 6'd22, ALU_SRLI  = 6'd23, ALU_SRAI  = 6'd24,
      ALU_SLL   = 6'd25, ALU_SLT   = 6'd26, ALU_SLTU  = 6'd27, ALU_SRL   = 6'd28,
      ALU_SRA   = 6'd29, ALU_SLTI  = 6'd30, ALU_SLTIU = 6'd31
   } alu_op_e;

   // branch compare results, rs1 against rs2
   typedef struct packed {
      logic eq;
      logic gt;   // signed
      logic gtu;  // unsigned
   } branch_flags_t;

endpackage

// ==== hw/alu_top.sv ====
module alu_top #(
   parameter int XLEN   = alu_op_pkg::XLEN,
   parameter int STAGES = muldiv_pkg::MUL_STAGES
) (
   input  logic                clk_i,
   input  logic                rst_i,
   input  logic                valid_i,
   input  alu_op_pkg::alu_op_e op_i,
   input  alu_op_pkg::word_t   rs1_i,
   input  alu_op_pkg::word_t   rs2_i,
   input  alu_op_pkg::word_t   imm_i,
   input  alu_op_pkg::word_t   pc_i,
   input  logic                branch_i,
   output logic                ready_o,
   output logic                stall_o,
   output logic                target_valid_o,
   output alu_op_pkg::word_t   result_o,
   output alu_op_pkg::word_t   target_o,
   output logic                eq_o,
   output logic                gt_o,
   output logic                gtu_o
);
   import alu_op_pkg::*;

   word_t         int_res;
   branch_flags_t flags;

   muldiv_if mul_if ();
   muldiv_if div_if ();

   int_alu #(.XLEN(XLEN)) int_alu_i (
      .op_i, .rs1_i, .rs2_i, .imm_i, .pc_i, .branch_i,
      .int_res_o     (int_res),
      .target_o,
      .target_valid_o,
      .flags_o       (flags)
   );

   alu_ctrl #(.XLEN(XLEN)) alu_ctrl_i (
      .clk_i, .rst_i, .valid_i, .op_i, .rs1_i, .rs2_i,
      .int_res_i (int_res),
      .mul_o     (mul_if),
      .div_o     (div_if),
      .result_o, .ready_o, .stall_o
   );

   pipe_mul #(.XLEN(XLEN), .STAGES(STAGES)) pipe_mul_i (.clk_i, .rst_i, .md_i(mul_if));

   iter_div #(.XLEN(XLEN)) iter_div_i (.clk_i, .rst_i, .md_i(div_if));

   assign eq_o  = flags.eq;
   assign gt_o  = flags.gt;
   assign gtu_o = flags.gtu;

endmodule

// ==== hw/int_alu.sv ====
module int_alu #(
   parameter int XLEN = alu_op_pkg::XLEN
) (
   input  alu_op_pkg::alu_op_e       op_i,
   input  alu_op_pkg::word_t         rs1_i,
   input  alu_op_pkg::word_t         rs2_i,
   input  alu_op_pkg::word_t         imm_i,
   input  alu_op_pkg::word_t         pc_i,
   input  logic                      branch_i,
   output alu_op_pkg::word_t         int_res_o,
   output alu_op_pkg::word_t         target_o,
   output logic                      target_valid_o,
   output alu_op_pkg::branch_flags_t flags_o
);
   import alu_op_pkg::*;

   localparam int SHW = $clog2(XLEN);

   logic            use_imm;
   logic            sub;
   logic [XLEN-1:0] opa;
   logic [XLEN-1:0] opb;
   logic [XLEN:0]   sum;      // top bit is the carry out
   logic            zero;
   logic            lt;       // signed opa < opb
   logic            geu;      // no borrow, opa >= opb unsigned
   logic [SHW-1:0]  shamt;
   logic            is_jump;

   assign use_imm = op_i inside {ALU_ADDI, ALU_ANDI, ALU_ORI, ALU_XORI, ALU_SLLI, ALU_SRLI,
                                 ALU_SRAI, ALU_SLTI, ALU_SLTIU, ALU_MEM, ALU_AUIPC};
   assign sub     = branch_i || op_i inside {ALU_SUB, ALU_SLT, ALU_SLTU, ALU_SLTI, ALU_SLTIU};

   // a branch compare takes the adder over with rs1 - rs2
   assign opa = (op_i == ALU_AUIPC && !branch_i) ? pc_i : rs1_i;
   assign opb = (use_imm && !branch_i) ? imm_i : rs2_i;
   assign sum = {1'b0, opa} + {1'b0, sub ? ~opb : opb} + {{XLEN{1'b0}}, sub};

   assign zero  = sum[XLEN-1:0] == '0;
   assign lt    = (opa[XLEN-1] != opb[XLEN-1]) ? opa[XLEN-1] : sum[XLEN-1];
   assign geu   = sum[XLEN];
   assign shamt = opb[SHW-1:0];

   always_comb begin
      flags_o = '0;
      if (branch_i) begin
         flags_o.eq  = zero;
         flags_o.gt  = !lt && !zero;
         flags_o.gtu = geu && !zero;
      end
   end

   always_comb begin
      case (op_i)
         ALU_ADD, ALU_ADDI, ALU_MEM,
         ALU_AUIPC, ALU_SUB:        int_res_o = sum[XLEN-1:0];
         ALU_LUI:                   int_res_o = imm_i;
         ALU_AND, ALU_ANDI:         int_res_o = rs1_i & opb;
         ALU_OR, ALU_ORI:           int_res_o = rs1_i | opb;
         ALU_XOR, ALU_XORI:         int_res_o = rs1_i ^ opb;
         ALU_SLL, ALU_SLLI:         int_res_o = rs1_i << shamt;
         ALU_SRL, ALU_SRLI:         int_res_o = rs1_i >> shamt;
         ALU_SRA, ALU_SRAI:         int_res_o = $signed(rs1_i) >>> shamt;
         ALU_SLT, ALU_SLTI:         int_res_o = {{(XLEN-1){1'b0}}, lt};
         ALU_SLTU, ALU_SLTIU:       int_res_o = {{(XLEN-1){1'b0}}, !geu};
         ALU_JAL, ALU_JALR:         int_res_o = pc_i + XLEN'(4); // link value
         default:                   int_res_o = '0;
      endcase
   end

   // jump target has its own adder, apart from the shared one
   assign is_jump        = op_i inside {ALU_JAL, ALU_JALR};
   assign target_valid_o = is_jump;
   assign target_o       = is_jump ? ((op_i == ALU_JALR ? rs1_i : pc_i) + imm_i) : '0;

endmodule

// ==== hw/iter_div.sv ====
module iter_div #(
   parameter int XLEN = alu_op_pkg::XLEN
) (
   input logic    clk_i,
   input logic    rst_i,
   muldiv_if.unit md_i
);
   import muldiv_pkg::*;

   localparam int CW = $clog2(XLEN + 1);

   logic            busy_q;
   logic [CW-1:0]   cnt_q;    // steps left
   md_op_e          op_q;
   logic            qneg_q;   // negate quotient at the end
   logic            rneg_q;   // remainder takes the dividend sign
   logic [XLEN-1:0] dvs_q;
   logic [XLEN-1:0] quo_q;    // dividend shifts out, quotient shifts in
   logic [XLEN-1:0] rem_q;
   logic            a_neg;
   logic            b_neg;
   logic [XLEN:0]   part;
   logic [XLEN+1:0] diff;
   logic [XLEN-1:0] quo_fix;
   logic [XLEN-1:0] rem_fix;

   assign a_neg = md_i.sgn && md_i.a[XLEN-1];
   assign b_neg = md_i.sgn && md_i.b[XLEN-1];
   assign part  = {rem_q, quo_q[XLEN-1]};
   assign diff  = {1'b0, part} - {2'b00, dvs_q};

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         busy_q <= 1'b0;
         cnt_q  <= '0;
      end else if (md_i.req) begin
         busy_q <= 1'b1;
         cnt_q  <= CW'(XLEN);
      end else if (busy_q) begin
         if (cnt_q == '0) begin
            busy_q <= 1'b0;
         end else begin
            cnt_q <= cnt_q - 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (md_i.req) begin
         op_q   <= md_i.op;
         // divide by zero already yields all ones, so keep that quotient positive
         qneg_q <= (a_neg ^ b_neg) && (md_i.b != '0);
         rneg_q <= a_neg;
         dvs_q  <= b_neg ? -md_i.b : md_i.b;
         quo_q  <= a_neg ? -md_i.a : md_i.a;
         rem_q  <= '0;
      end else if (busy_q && cnt_q != '0) begin
         if (!diff[XLEN+1]) begin                  // fits, keep the difference
            rem_q <= diff[XLEN-1:0];
            quo_q <= {quo_q[XLEN-2:0], 1'b1};
         end else begin                            // restore
            rem_q <= part[XLEN-1:0];
            quo_q <= {quo_q[XLEN-2:0], 1'b0};
         end
      end
   end

   // overflow falls out of the magnitudes: 2^(XLEN-1) / 1, both negated
   assign quo_fix   = qneg_q ? -quo_q : quo_q;
   assign rem_fix   = rneg_q ? -rem_q : rem_q;
   assign md_i.done = busy_q && cnt_q == '0;
   assign md_i.res  = (op_q == MD_HI) ? rem_fix : quo_fix;

   // the controller must wait for done before issuing again
   a_no_req_busy: assert property (@(posedge clk_i) disable iff (!rst_i)
      md_i.req |-> !busy_q);

endmodule

// ==== hw/muldiv_if.sv ====
interface muldiv_if;
   import alu_op_pkg::*;
   import muldiv_pkg::*;

   logic   req;  // one cycle per operation
   md_op_e op;
   logic   sgn;  // operands are signed
   word_t  a;
   word_t  b;
   logic   done; // one cycle, res valid with it
   word_t  res;

   modport ctrl (
      output req, op, sgn, a, b,
      input  done, res
   );

   modport unit (
      input  req, op, sgn, a, b,
      output done, res
   );

endinterface

// ==== hw/muldiv_pkg.sv ====
package muldiv_pkg;

   // multiplier: low half, signed high half, unsigned high half
   // divider: MD_LO selects the quotient, MD_HI the remainder
   typedef enum logic [1:0] {
      MD_LO  = 2'd0,
      MD_HI  = 2'd1,
      MD_HIU = 2'd2
   } md_op_e;

   // register depth of the multiplier pipeline
   parameter int MUL_STAGES = 3;

endpackage

// ==== hw/pipe_mul.sv ====
module pipe_mul #(
   parameter int XLEN   = alu_op_pkg::XLEN,
   parameter int STAGES = muldiv_pkg::MUL_STAGES
) (
   input logic    clk_i,
   input logic    rst_i,
   muldiv_if.unit md_i
);
   import muldiv_pkg::*;

   logic signed [XLEN:0]     a_ext;
   logic signed [XLEN:0]     b_ext;
   logic signed [2*XLEN+1:0] prod;
   logic [2*XLEN-1:0]        prod_q [STAGES];
   md_op_e                   op_q   [STAGES];
   logic [STAGES-1:0]        vld_q;
   logic [2*XLEN-1:0]        last;

   // one extra bit so a single signed multiply covers both modes
   assign a_ext = {md_i.sgn && md_i.a[XLEN-1], md_i.a};
   assign b_ext = {md_i.sgn && md_i.b[XLEN-1], md_i.b};
   assign prod  = a_ext * b_ext;

   // product and op ride along, retiming spreads the multiply over the stages
   always_ff @(posedge clk_i) begin
      prod_q[0] <= prod[2*XLEN-1:0];
      op_q[0]   <= md_i.op;
      for (int i = 1; i < STAGES; i++) begin
         prod_q[i] <= prod_q[i-1];
         op_q[i]   <= op_q[i-1];
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         vld_q <= '0;
      end else begin
         vld_q[0] <= md_i.req;
         for (int i = 1; i < STAGES; i++) begin
            vld_q[i] <= vld_q[i-1];
         end
      end
   end

   assign last      = prod_q[STAGES-1];
   assign md_i.done = vld_q[STAGES-1];
   assign md_i.res  = (op_q[STAGES-1] == MD_LO) ? last[XLEN-1:0] : last[2*XLEN-1:XLEN];

endmodule

// ==== tests/alu_golden.txt ====
// op rs1 rs2 imm pc branch result target flags, all hex
// flags packs eq gt gtu from bit 2 down to bit 0
00 00000005 00000007 00000000 00000000 0 0000000c 00000000 0
01 00001000 00000000 fffffff0 00000000 0 00000ff0 00000000 0
0f 00000003 00000005 00000000 00000000 0 fffffffe 00000000 0
10 f0f0f0f0 ff00ff00 00000000 00000000 0 f000f000 00000000 0
11 12345678 00000000 000000ff 00000000 0 00000078 00000000 0
12 f0f0f0f0 0f0f0f0f 00000000 00000000 0 ffffffff 00000000 0
13 aaaaaaaa ffff0000 00000000 00000000 0 5555aaaa 00000000 0
15 12345678 00000000 ffffffff 00000000 0 edcba987 00000000 0
19 00000001 0000001f 00000000 00000000 0 80000000 00000000 0
1c 80000000 00000024 00000000 00000000 0 08000000 00000000 0
1d 80000000 00000004 00000000 00000000 0 f8000000 00000000 0
18 7ffffff0 00000000 00000004 00000000 0 07ffffff 00000000 0
1a ffffffff 00000001 00000000 00000000 0 00000001 00000000 0
1b ffffffff 00000001 00000000 00000000 0 00000000 00000000 0
1e 00000005 00000000 fffffffb 00000000 0 00000000 00000000 0
1f 00000005 00000000 fffffffb 00000000 0 00000001 00000000 0
0b 00000000 00000000 12345000 00000000 0 12345000 00000000 0
0a 00000000 00000000 00002000 00000100 0 00002100 00000000 0
0e 00001000 00000000 fffffffc 00000000 0 00000ffc 00000000 0
0c 00000000 00000000 00000040 00000200 0 00000204 00000240 0
0d 00008000 00000000 fffffff0 00000300 0 00000304 00007ff0 0
0f 00000005 00000005 00000000 00000000 1 00000000 00000000 4
0f ffffffff 00000001 00000000 00000000 1 fffffffe 00000000 1
0f 00000001 80000000 00000000 00000000 1 80000001 00000000 2
02 fffffffe 00000003 00000000 00000000 0 fffffffa 00000000 0
03 80000000 80000000 00000000 00000000 0 40000000 00000000 0
05 ffffffff ffffffff 00000000 00000000 0 fffffffe 00000000 0
06 fffffff9 00000002 00000000 00000000 0 fffffffd 00000000 0
08 fffffff9 00000002 00000000 00000000 0 ffffffff 00000000 0
07 00000064 00000007 00000000 00000000 0 0000000e 00000000 0
09 00000064 00000007 00000000 00000000 0 00000002 00000000 0
06 00000010 00000000 00000000 00000000 0 ffffffff 00000000 0
08 fffffff0 00000000 00000000 00000000 0 fffffff0 00000000 0
06 80000000 ffffffff 00000000 00000000 0 80000000 00000000 0
08 80000000 ffffffff 00000000 00000000 0 00000000 00000000 0

// ==== tests/tb_alu.sv ====
module tb_alu;
   timeunit 1ns;
   timeprecision 100ps;
   import alu_op_pkg::*;

   localparam int NUM_VEC = 35;
   localparam int COLS    = 9;   // words per golden line
   localparam int TIMEOUT = NUM_VEC * (XLEN + 8) + 16;

   logic        clk;
   logic        rst;
   logic        valid;
   alu_op_e     op;
   word_t       rs1;
   word_t       rs2;
   word_t       imm;
   word_t       pc;
   logic        branch;
   logic        ready;
   logic        stall;
   logic        target_valid;
   word_t       result;
   word_t       target;
   logic        eq;
   logic        gt;
   logic        gtu;
   logic [31:0] gold [NUM_VEC*COLS];
   logic [31:0] rng;
   int          cycle_cnt;

   tb_clock #(.PERIOD_NS(4), .RESET_CYCLES(16)) tb_clock_i (.clk_o(clk), .rst_o(rst));

   alu_top #(.XLEN(XLEN), .STAGES(muldiv_pkg::MUL_STAGES)) alu_top_i (
      .clk_i          (clk),
      .rst_i          (rst),
      .valid_i        (valid),
      .op_i           (op),
      .rs1_i          (rs1),
      .rs2_i          (rs2),
      .imm_i          (imm),
      .pc_i           (pc),
      .branch_i       (branch),
      .ready_o        (ready),
      .stall_o        (stall),
      .target_valid_o (target_valid),
      .result_o       (result),
      .target_o       (target),
      .eq_o           (eq),
      .gt_o           (gt),
      .gtu_o          (gtu)
   );

   function automatic logic [31:0] next_random(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("Something failed");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_word(input string name, input word_t exp, input word_t act);
      if (act !== exp) begin
         report_failure($sformatf("Error: %s: expected %h, actual %h", name, exp, act));
      end
   endtask

   task automatic check_flags(input string name, input branch_flags_t exp,
                              input branch_flags_t act);
      if (act !== exp) begin
         report_failure($sformatf("Error: %s: expected eq/gt/gtu %b, actual %b", name, exp, act));
      end
   endtask

   // drive one golden line and hold it until ready_o
   task automatic run_vector(input int idx);
      int            base;
      int            waited;
      alu_op_e       v_op;
      logic          is_long;
      logic          is_jump;
      string         name;
      base    = idx * COLS;
      waited  = 0;
      v_op    = alu_op_e'(gold[base][5:0]);
      name    = $sformatf("vector %0d %s", idx, v_op.name());
      is_long = v_op inside {ALU_MUL, ALU_MULH, ALU_MULHU, ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};
      is_jump = v_op inside {ALU_JAL, ALU_JALR};
      @(posedge clk);
      valid  <= 1'b1;
      op     <= v_op;
      rs1    <= gold[base+1];
      rs2    <= gold[base+2];
      imm    <= gold[base+3];
      pc     <= gold[base+4];
      branch <= gold[base+5][0];
      @(negedge clk);
      if (ready !== 1'b0) begin
         report_failure({name, ": ready_o high before the operation could finish"});
      end
      if (target_valid !== is_jump) begin
         report_failure({name, ": target_valid_o does not match the jump type"});
      end
      check_word({name, " target"}, gold[base+7], target);
      check_flags({name, " flags"}, branch_flags_t'(gold[base+8][2:0]), {eq, gt, gtu});
      while (ready !== 1'b1) begin
         if (stall !== is_long) begin
            report_failure({name, ": stall_o wrong while the operation runs"});
         end
         @(negedge clk);
         waited = waited + 1;
      end
      if (!is_long && waited != 1) begin
         report_failure({name, ": ready_o not one cycle after issue"});
      end
      if (stall !== 1'b0) begin
         report_failure({name, ": stall_o still high together with ready_o"});
      end
      check_word({name, " result"}, gold[base+6], result);
   endtask

   // cycle limit, counted from reset release
   always @(posedge clk) begin
      if (rst === 1'b1) begin
         cycle_cnt <= cycle_cnt + 1;
         if (cycle_cnt >= TIMEOUT) begin
            report_failure($sformatf("timeout: vectors not done after %0d cycles", cycle_cnt));
         end
      end
   end

   initial begin
      int gap;
      valid     <= 1'b0;
      op        <= ALU_ADD;
      rs1       <= '0;
      rs2       <= '0;
      imm       <= '0;
      pc        <= '0;
      branch    <= 1'b0;
      cycle_cnt = 0;
      rng       = 32'hcc08c544;
      $readmemh("tests/alu_golden.txt", gold);
      if ($isunknown(gold[NUM_VEC*COLS-1])) begin
         report_failure("golden file holds fewer vectors than expected");
      end

      wait (rst === 1'b1);
      @(negedge clk);
      if (ready !== 1'b0 || stall !== 1'b0 || target_valid !== 1'b0) begin
         report_failure("ready_o, stall_o or target_valid_o not low after reset");
      end
      check_word("reset result", '0, result);
      check_flags("reset flags", '0, {eq, gt, gtu});

      for (int i = 0; i < NUM_VEC; i++) begin
         run_vector(i);
         rng = next_random(rng);
         gap = int'(rng % 4);   // idle cycles before the next op
         if (gap > 0) begin
            @(posedge clk);
            valid  <= 1'b0;
            branch <= 1'b0;
            @(negedge clk);
            if (ready !== 1'b0) begin
               report_failure($sformatf("vector %0d: ready_o high for more than one cycle", i));
            end
            repeat (gap - 1) @(posedge clk);
         end
      end

      @(posedge clk);
      valid <= 1'b0;
      @(negedge clk);
      if (ready !== 1'b0) begin
         report_failure("ready_o stayed high for more than one cycle");
      end
      $display("Everything OK");
      $finish;
   end

endmodule

// ==== tests/tb_clock.sv ====
module tb_clock #(
   parameter int PERIOD_NS    = 4,
   parameter int RESET_CYCLES = 16
) (
   output logic clk_o,
   output logic rst_o   // active low
);
   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
   end

   initial begin
      rst_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      rst_o <= 1'b1;
   end

endmodule
